// ==== src/l2_cache_pkg.sv ====
//--------------------
// shared geometry and types for the L2 cache
// referenced by scoped name from the interface, the ways, the
// controller, the selector and the top level
//--------------------

`default_nettype none

package l2_cache_pkg;

    // byte address and line geometry
    localparam int addr_bits   = 32;
    localparam int offset_bits = 5;   // 32-byte lines
    localparam int line_bits   = 256;

    typedef logic [addr_bits-1:0] addr_t;
    typedef logic [line_bits-1:0] line_t;   // one full cache line

    // controller FSM states
    typedef enum logic [1:0] {
        state_idle,        // waiting for a request
        state_compare,     // tag check, respond on hit
        state_writeback,   // dirty victim going out to pmem
        state_allocate     // line fill from pmem
    } ctrl_state_t;

endpackage : l2_cache_pkg

`default_nettype wire

// ==== src/l2_way_if.sv ====
//--------------------
// link between one way block, the controller and the way selector
// instantiated as an array at the top level, one per way
//--------------------

`timescale 1ns/10ps
`default_nettype none

interface l2_way_if #(
    parameter int s_index = 3
) ();

    localparam int s_tag = l2_cache_pkg::addr_bits - l2_cache_pkg::offset_bits - s_index;

    // controller side
    logic [s_index-1:0]  index;
    logic [s_tag-1:0]    tag;
    l2_cache_pkg::line_t wdata;
    logic                tag_load;
    logic                valid_load;
    logic                valid_in;
    logic                dirty_load;
    logic                dirty_in;
    logic                data_we;

    // way side, all combinational from index
    logic                hit;
    logic                valid;
    logic                dirty;
    logic [s_tag-1:0]    way_tag;
    l2_cache_pkg::line_t rdata;

    modport ctrl (
        output index, tag, wdata,
        output tag_load, valid_load, valid_in, dirty_load, dirty_in, data_we,
        input  valid
    );

    modport way (
        input  index, tag, wdata,
        input  tag_load, valid_load, valid_in, dirty_load, dirty_in, data_we,
        output hit, valid, dirty, way_tag, rdata
    );

    modport sel (
        input hit, dirty, way_tag, rdata
    );

endinterface : l2_way_if

`default_nettype wire

// ==== src/l2_cache_way.sv ====
//--------------------
// one way of the set-associative cache
// valid, dirty, tag and line storage for every set, plus tag compare
// reads are combinational, writes land on the strobe edge
//--------------------

`timescale 1ns/10ps
`default_nettype none

module l2_cache_way #(
    parameter int s_index = 3
) (
    input  logic   clk,
    input  logic   rst_n,
    l2_way_if.way  port
);

    localparam int s_tag    = l2_cache_pkg::addr_bits - l2_cache_pkg::offset_bits - s_index;
    localparam int num_sets = 2**s_index;

    logic [num_sets-1:0] valid_arr;
    logic [num_sets-1:0] dirty_arr;
    logic [s_tag-1:0]    tag_arr [num_sets];
    l2_cache_pkg::line_t data_arr [num_sets];

    logic             cur_valid;
    logic [s_tag-1:0] cur_tag;

    assign cur_valid = valid_arr[port.index];
    assign cur_tag   = tag_arr[port.index];

    // read side of the indexed set
    assign port.valid   = cur_valid;
    assign port.dirty   = dirty_arr[port.index];
    assign port.way_tag = cur_tag;
    assign port.rdata   = data_arr[port.index];
    assign port.hit     = cur_valid && (cur_tag == port.tag);

    // status bits, cleared by reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_arr <= '0;
            dirty_arr <= '0;
        end else begin
            if (port.valid_load) begin
                valid_arr[port.index] <= port.valid_in;
            end
            if (port.dirty_load) begin
                dirty_arr[port.index] <= port.dirty_in;
            end
        end
    end

    // tag and line payload
    always_ff @(posedge clk) begin
        if (port.tag_load) begin
            tag_arr[port.index] <= port.tag;
        end
        if (port.data_we) begin
            data_arr[port.index] <= port.wdata;   // always a whole line
        end
    end

endmodule : l2_cache_way

`default_nettype wire

// ==== src/l2_cache_control.sv ====
//--------------------
// cache controller: idle/compare/writeback/allocate FSM
// keeps per-set LRU ages and drives the load strobes of every way
// mem_resp is registered, one cycle after the hit is seen in compare
//--------------------

`timescale 1ns/10ps
`default_nettype none

module l2_cache_control #(
    parameter int  s_index  = 3,
    parameter int  num_ways = 4,
    localparam int s_tag    = l2_cache_pkg::addr_bits - l2_cache_pkg::offset_bits - s_index,
    localparam int way_bits = (num_ways > 1) ? $clog2(num_ways) : 1
) (
    input  logic                clk,
    input  logic                rst_n,

    // upstream side
    input  l2_cache_pkg::addr_t mem_address,
    input  l2_cache_pkg::line_t mem_wdata256,
    input  logic                mem_read,
    input  logic                mem_write,
    output logic                mem_resp,

    // physical memory side
    output l2_cache_pkg::addr_t pmem_address,
    output logic                pmem_read,
    output logic                pmem_write,
    input  l2_cache_pkg::line_t pmem_rdata,
    input  logic                pmem_resp,

    // ways and selector
    l2_way_if.ctrl              ways [num_ways],
    input  logic                hit,
    input  logic [way_bits-1:0] hit_way,
    output logic [way_bits-1:0] victim,
    input  logic                victim_dirty,
    input  logic [s_tag-1:0]    victim_tag
);

    localparam int num_sets = 2**s_index;

    l2_cache_pkg::ctrl_state_t state;
    l2_cache_pkg::ctrl_state_t state_next;

    logic [s_index-1:0]  index;
    logic [s_tag-1:0]    tag;
    logic                request;
    logic [num_ways-1:0] valid_vec;
    logic [way_bits-1:0] ages [num_sets][num_ways];   // 0 is most recent
    logic [way_bits-1:0] free_way;
    logic                any_free;
    logic [way_bits-1:0] lru_way;
    l2_cache_pkg::line_t wdata_mux;

    logic [num_ways-1:0] data_we_vec;
    logic [num_ways-1:0] tag_load_vec;
    logic [num_ways-1:0] valid_load_vec;
    logic [num_ways-1:0] dirty_load_vec;
    logic                dirty_in_val;
    logic                lru_touch;

    assign index = mem_address[l2_cache_pkg::offset_bits +: s_index];
    assign tag   = mem_address[l2_cache_pkg::addr_bits-1 -: s_tag];

    // ignore the request still held during the response cycle
    assign request = (mem_read || mem_write) && !mem_resp;

    // victim choice: lowest invalid way, else the oldest one
    always_comb begin
        free_way = '0;
        any_free = 1'b0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid_vec[w]) begin
                free_way = way_bits'(w);
                any_free = 1'b1;
            end
        end
        lru_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (ages[index][w] == way_bits'(num_ways - 1)) begin
                lru_way = way_bits'(w);
            end
        end
    end

    assign victim = any_free ? free_way : lru_way;

    always_comb begin
        state_next     = state;
        data_we_vec    = '0;
        tag_load_vec   = '0;
        valid_load_vec = '0;
        dirty_load_vec = '0;
        dirty_in_val   = 1'b0;
        lru_touch      = 1'b0;
        case (state)
            l2_cache_pkg::state_idle: begin
                if (request) begin
                    state_next = l2_cache_pkg::state_compare;
                end
            end
            l2_cache_pkg::state_compare: begin
                if (hit) begin
                    lru_touch  = 1'b1;
                    state_next = l2_cache_pkg::state_idle;
                    if (mem_write) begin   // write hit marks the line dirty
                        data_we_vec[hit_way]    = 1'b1;
                        dirty_load_vec[hit_way] = 1'b1;
                        dirty_in_val            = 1'b1;
                    end
                end else if (victim_dirty) begin
                    state_next = l2_cache_pkg::state_writeback;
                end else begin
                    state_next = l2_cache_pkg::state_allocate;
                end
            end
            l2_cache_pkg::state_writeback: begin
                if (pmem_resp) begin
                    state_next = l2_cache_pkg::state_allocate;
                end
            end
            l2_cache_pkg::state_allocate: begin
                if (pmem_resp) begin
                    // fill the victim, clean and valid
                    data_we_vec[victim]    = 1'b1;
                    tag_load_vec[victim]   = 1'b1;
                    valid_load_vec[victim] = 1'b1;
                    dirty_load_vec[victim] = 1'b1;
                    state_next             = l2_cache_pkg::state_compare;
                end
            end
            default: state_next = l2_cache_pkg::state_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= l2_cache_pkg::state_idle;
            mem_resp <= 1'b0;
        end else begin
            state    <= state_next;
            mem_resp <= (state == l2_cache_pkg::state_compare) && hit;
        end
    end

    // age update on every hit: touched way to 0, younger ones age by one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    ages[s][w] <= way_bits'(w);
                end
            end
        end else if (lru_touch) begin
            for (int w = 0; w < num_ways; w++) begin
                if (way_bits'(w) == hit_way) begin
                    ages[index][w] <= '0;
                end else if (ages[index][w] < ages[index][hit_way]) begin
                    ages[index][w] <= ages[index][w] + 1'b1;
                end
            end
        end
    end

    // pmem request levels follow the state
    assign pmem_read  = (state == l2_cache_pkg::state_allocate);
    assign pmem_write = (state == l2_cache_pkg::state_writeback);
    assign pmem_address = (state == l2_cache_pkg::state_writeback) ?
                          {victim_tag, index, {l2_cache_pkg::offset_bits{1'b0}}} :
                          {tag, index, {l2_cache_pkg::offset_bits{1'b0}}};

    assign wdata_mux = (state == l2_cache_pkg::state_allocate) ? pmem_rdata : mem_wdata256;

    for (genvar g = 0; g < num_ways; g++) begin : g_way
        assign ways[g].index      = index;
        assign ways[g].tag        = tag;
        assign ways[g].wdata      = wdata_mux;
        assign ways[g].tag_load   = tag_load_vec[g];
        assign ways[g].valid_load = valid_load_vec[g];
        assign ways[g].valid_in   = 1'b1;   // lines only ever become valid
        assign ways[g].dirty_load = dirty_load_vec[g];
        assign ways[g].dirty_in   = dirty_in_val;
        assign ways[g].data_we    = data_we_vec[g];
        assign valid_vec[g]       = ways[g].valid;
    end

endmodule : l2_cache_control

`default_nettype wire

// ==== src/l2_way_select.sv ====
//--------------------
// combinational reduction over the ways
// gives the hit flag, hit way and read line, and muxes out the victim
//--------------------

`timescale 1ns/10ps
`default_nettype none

module l2_way_select #(
    parameter int  s_index  = 3,
    parameter int  num_ways = 4,
    localparam int s_tag    = l2_cache_pkg::addr_bits - l2_cache_pkg::offset_bits - s_index,
    localparam int way_bits = (num_ways > 1) ? $clog2(num_ways) : 1
) (
    l2_way_if.sel               ways [num_ways],
    input  logic [way_bits-1:0] victim,
    output logic                hit,
    output logic [way_bits-1:0] hit_way,
    output l2_cache_pkg::line_t rdata,
    output logic                victim_dirty,
    output logic [s_tag-1:0]    victim_tag,
    output l2_cache_pkg::line_t victim_line
);

    logic [num_ways-1:0] hit_vec;
    logic [num_ways-1:0] dirty_vec;
    logic [s_tag-1:0]    tag_arr [num_ways];
    l2_cache_pkg::line_t line_arr [num_ways];

    // flatten the interface array
    for (genvar g = 0; g < num_ways; g++) begin : g_gather
        assign hit_vec[g]   = ways[g].hit;
        assign dirty_vec[g] = ways[g].dirty;
        assign tag_arr[g]   = ways[g].way_tag;
        assign line_arr[g]  = ways[g].rdata;
    end

    assign hit = |hit_vec;

    // at most one way hits, so a plain encoder will do
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_vec[w]) begin
                hit_way = way_bits'(w);
            end
        end
    end

    assign rdata = line_arr[hit_way];

    assign victim_dirty = dirty_vec[victim];
    assign victim_tag   = tag_arr[victim];
    assign victim_line  = line_arr[victim];   // goes out as pmem_wdata

endmodule : l2_way_select

`default_nettype wire

// ==== src/l2_cache.sv ====
//--------------------
// L2 cache top level, 256-bit lines on both sides
// controller, num_ways way blocks and the way selector on plain ports
//--------------------

`timescale 1ns/10ps
`default_nettype none

module l2_cache #(
    parameter int s_index  = 3,
    parameter int num_ways = 4
) (
    input  logic                clk,
    input  logic                rst_n,

    // upstream cache
    input  l2_cache_pkg::addr_t mem_address,
    output l2_cache_pkg::line_t mem_rdata256,
    input  l2_cache_pkg::line_t mem_wdata256,
    input  logic                mem_read,
    input  logic                mem_write,
    output logic                mem_resp,

    // physical memory
    output l2_cache_pkg::addr_t pmem_address,
    input  l2_cache_pkg::line_t pmem_rdata,
    output l2_cache_pkg::line_t pmem_wdata,
    output logic                pmem_read,
    output logic                pmem_write,
    input  logic                pmem_resp
);

    localparam int s_tag    = l2_cache_pkg::addr_bits - l2_cache_pkg::offset_bits - s_index;
    localparam int way_bits = (num_ways > 1) ? $clog2(num_ways) : 1;

    logic                hit;
    logic [way_bits-1:0] hit_way;
    logic [way_bits-1:0] victim;
    logic                victim_dirty;
    logic [s_tag-1:0]    victim_tag;

    l2_way_if #(.s_index(s_index)) way_bus [num_ways] ();

    l2_cache_control #(
        .s_index  (s_index),
        .num_ways (num_ways)
    ) control_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_address  (mem_address),
        .mem_wdata256 (mem_wdata256),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_resp     (mem_resp),
        .pmem_address (pmem_address),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp),
        .ways         (way_bus),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim       (victim),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    for (genvar g = 0; g < num_ways; g++) begin : g_way
        l2_cache_way #(
            .s_index (s_index)
        ) way_i (
            .clk   (clk),
            .rst_n (rst_n),
            .port  (way_bus[g])
        );
    end

    l2_way_select #(
        .s_index  (s_index),
        .num_ways (num_ways)
    ) select_i (
        .ways         (way_bus),
        .victim       (victim),
        .hit          (hit),
        .hit_way      (hit_way),
        .rdata        (mem_rdata256),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_line  (pmem_wdata)   // writeback data straight from the victim
    );

endmodule : l2_cache

`default_nettype wire

// ==== tests/l2_pmem_model.sv ====
//--------------------
// behavioral physical memory for the L2 cache testbench
// answers a held read or write with a one-cycle resp after latency edges
// unwritten lines read back as a fixed function of the line address
//--------------------

`timescale 1ns/10ps
`default_nettype none

module l2_pmem_model #(
    parameter int latency    = 4,
    parameter int store_bits = 10   // line store decodes addr[14:5]
) (
    input  logic                clk,
    input  logic                rst_n,
    input  l2_cache_pkg::addr_t address,
    input  l2_cache_pkg::line_t wdata,
    output l2_cache_pkg::line_t rdata,
    input  logic                read,
    input  logic                write,
    output logic                resp
);

    localparam int store_lines = 2**store_bits;

    l2_cache_pkg::line_t   store [store_lines];
    logic                  written [store_lines];
    logic [store_bits-1:0] key;
    int                    wait_count;

    assign key = address[l2_cache_pkg::offset_bits +: store_bits];

    // contents of a line that was never written
    function automatic l2_cache_pkg::line_t initial_line(input l2_cache_pkg::addr_t a);
        l2_cache_pkg::line_t l;
        for (int k = 0; k < 8; k++) begin
            l[32*k +: 32] = {a[15:0], a[31:16]} ^ 32'(a * (k + 1)) ^ 32'h6a09_e667;
        end
        return l;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            resp       <= 1'b0;
            rdata      <= '0;
            wait_count <= 0;
            for (int i = 0; i < store_lines; i++) begin
                written[i] <= 1'b0;
            end
        end else if (resp) begin
            resp       <= 1'b0;   // single-cycle pulse
            wait_count <= 0;
        end else if (read || write) begin
            if (wait_count == latency - 1) begin
                resp       <= 1'b1;
                wait_count <= 0;
                if (write) begin
                    store[key]   <= wdata;
                    written[key] <= 1'b1;
                end else begin
                    rdata <= written[key] ? store[key] : initial_line(address);
                end
            end else begin
                wait_count <= wait_count + 1;
            end
        end
    end

endmodule : l2_pmem_model

`default_nettype wire

// ==== tests/l2_cache_tb.sv ====
//--------------------
// testbench for the L2 cache top level
// shadow memory plus LRU reference model, checked by immediate assertions
// directed reset, hit, write and eviction cases, then a seeded random mix
//--------------------

`timescale 1ns/10ps
`default_nettype none

module l2_cache_tb;

    localparam int s_index    = 3;
    localparam int num_ways   = 4;
    localparam int num_sets   = 2**s_index;
    localparam int s_tag      = l2_cache_pkg::addr_bits - l2_cache_pkg::offset_bits - s_index;
    localparam int max_cycles = 4000;
    localparam int random_ops = 150;
    localparam logic [s_tag-1:0] base_tag = 'h5a_3e0;   // low nibble clear

    logic                clk;
    logic                rst_n;
    l2_cache_pkg::addr_t mem_address;
    l2_cache_pkg::line_t mem_rdata256;
    l2_cache_pkg::line_t mem_wdata256;
    logic                mem_read;
    logic                mem_write;
    logic                mem_resp;
    l2_cache_pkg::addr_t pmem_address;
    l2_cache_pkg::line_t pmem_rdata;
    l2_cache_pkg::line_t pmem_wdata;
    logic                pmem_read;
    logic                pmem_write;
    logic                pmem_resp;

    int                  errors;
    int                  cycle_count;
    int                  seed;
    int                  pmem_reads;
    int                  pmem_writes;
    l2_cache_pkg::addr_t wb_addr;   // last line written back
    l2_cache_pkg::line_t wb_data;
    logic                prev_pending;
    logic                prev_write;
    logic                prev_resp;
    l2_cache_pkg::addr_t prev_addr;
    l2_cache_pkg::line_t prev_wdata;

    // reference model of the tag store
    logic                m_valid [num_sets][num_ways];
    logic                m_dirty [num_sets][num_ways];
    logic [s_tag-1:0]    m_tag [num_sets][num_ways];
    int                  m_used [num_sets][num_ways];
    int                  use_time;
    l2_cache_pkg::line_t shadow [128];   // keyed by addr[11:5]
    logic                shadow_ok [128];

    l2_cache #(
        .s_index  (s_index),
        .num_ways (num_ways)
    ) l2_cache_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_address  (mem_address),
        .mem_rdata256 (mem_rdata256),
        .mem_wdata256 (mem_wdata256),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_resp     (mem_resp),
        .pmem_address (pmem_address),
        .pmem_rdata   (pmem_rdata),
        .pmem_wdata   (pmem_wdata),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_resp    (pmem_resp)
    );

    l2_pmem_model #(
        .latency (4)
    ) pmem_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .address (pmem_address),
        .wdata   (pmem_wdata),
        .rdata   (pmem_rdata),
        .read    (pmem_read),
        .write   (pmem_write),
        .resp    (pmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic report_error(input string msg);
        errors++;
        $display("** Error at %0t: %s", $time, msg);
    endtask

    // same pattern the memory model starts with
    function automatic l2_cache_pkg::line_t expected_fill(input l2_cache_pkg::addr_t a);
        l2_cache_pkg::line_t l;
        for (int k = 0; k < 8; k++) begin
            l[32*k +: 32] = {a[15:0], a[31:16]} ^ 32'(a * (k + 1)) ^ 32'h6a09_e667;
        end
        return l;
    endfunction

    function automatic l2_cache_pkg::line_t expected_line(input l2_cache_pkg::addr_t a);
        return shadow_ok[a[11:5]] ? shadow[a[11:5]] : expected_fill(a);
    endfunction

    function automatic l2_cache_pkg::addr_t make_addr(input int t, input int set);
        return {base_tag + s_tag'(t), s_index'(set), {l2_cache_pkg::offset_bits{1'b0}}};
    endfunction

    function automatic int find_way(input int set, input logic [s_tag-1:0] tag);
        int w_hit;
        w_hit = -1;
        for (int w = 0; w < num_ways; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) begin
                w_hit = w;
            end
        end
        return w_hit;
    endfunction

    // lowest invalid way, else least recently used
    function automatic int choose_victim(input int set);
        int v;
        v = -1;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!m_valid[set][w]) begin
                v = w;
            end
        end
        if (v < 0) begin
            v = 0;
            for (int w = 1; w < num_ways; w++) begin
                if (m_used[set][w] < m_used[set][v]) begin
                    v = w;
                end
            end
        end
        return v;
    endfunction

    task automatic random_line(output l2_cache_pkg::line_t l);
        for (int k = 0; k < 8; k++) begin
            l[32*k +: 32] = $random(seed);
        end
    endtask

    task automatic check_idle();
        assert (mem_resp === 1'b0 && pmem_read === 1'b0 && pmem_write === 1'b0)
            else report_error("mem_resp, pmem_read or pmem_write not low after reset");
    endtask

    // one upstream request, predicted from the model and checked on completion
    task automatic cache_access(input logic is_write, input l2_cache_pkg::addr_t addr,
                                input l2_cache_pkg::line_t data);
        logic [s_index-1:0]  set;
        logic [s_tag-1:0]    tag;
        int                  hit_way;
        int                  victim;
        int                  way;
        int                  exp_writes;
        int                  reads0;
        int                  writes0;
        int                  cycles;
        l2_cache_pkg::addr_t victim_addr;
        l2_cache_pkg::line_t victim_data;
        l2_cache_pkg::line_t exp_rdata;
        l2_cache_pkg::line_t got;
        set        = addr[l2_cache_pkg::offset_bits +: s_index];
        tag        = addr[l2_cache_pkg::addr_bits-1 -: s_tag];
        hit_way    = find_way(set, tag);
        victim     = choose_victim(set);
        exp_writes = (hit_way < 0 && m_valid[set][victim] && m_dirty[set][victim]) ? 1 : 0;
        victim_addr = {m_tag[set][victim], set, {l2_cache_pkg::offset_bits{1'b0}}};
        victim_data = expected_line(victim_addr);
        exp_rdata  = expected_line(addr);
        reads0     = pmem_reads;
        writes0    = pmem_writes;

        @(negedge clk);
        mem_address  = addr;
        mem_wdata256 = data;
        mem_read     = !is_write;
        mem_write    = is_write;
        cycles       = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!mem_resp);
        got = mem_rdata256;
        @(negedge clk);   // resp seen on the edge, drop the request
        mem_read  = 1'b0;
        mem_write = 1'b0;

        if (!is_write) begin
            assert (got === exp_rdata)
                else report_error($sformatf("read %h returned %h, expected %h",
                                            addr, got, exp_rdata));
        end
        if (hit_way >= 0) begin
            assert (cycles == 2)
                else report_error($sformatf("hit on %h took %0d cycles", addr, cycles));
        end
        assert (pmem_reads - reads0 == ((hit_way < 0) ? 1 : 0))
            else report_error($sformatf("access %h made %0d pmem reads",
                                        addr, pmem_reads - reads0));
        assert (pmem_writes - writes0 == exp_writes)
            else report_error($sformatf("access %h made %0d pmem writes",
                                        addr, pmem_writes - writes0));
        if (exp_writes == 1) begin
            assert (wb_addr === victim_addr && wb_data === victim_data)
                else report_error($sformatf("writeback to %h, expected victim %h",
                                            wb_addr, victim_addr));
        end

        way = (hit_way >= 0) ? hit_way : victim;
        if (hit_way < 0) begin   // fill leaves the line clean
            m_valid[set][way] = 1'b1;
            m_dirty[set][way] = 1'b0;
            m_tag[set][way]   = tag;
        end
        if (is_write) begin
            m_dirty[set][way]     = 1'b1;
            shadow[addr[11:5]]    = data;
            shadow_ok[addr[11:5]] = 1'b1;
        end
        use_time++;
        m_used[set][way] = use_time;
    endtask

    // pmem traffic counters and request stability
    always @(negedge clk) begin
        if (rst_n) begin
            assert (!(pmem_read && pmem_write))
                else report_error("pmem_read and pmem_write high together");
            assert (!(prev_resp && mem_resp))
                else report_error("mem_resp longer than one cycle");
            if (prev_pending) begin
                assert ((pmem_read || pmem_write) && pmem_write === prev_write &&
                        pmem_address === prev_addr &&
                        (!prev_write || pmem_wdata === prev_wdata))
                    else report_error("pmem request changed before pmem_resp");
            end
            if (pmem_resp && pmem_read) begin
                pmem_reads++;
            end
            if (pmem_resp && pmem_write) begin
                pmem_writes++;
                wb_addr = pmem_address;
                wb_data = pmem_wdata;
            end
            prev_pending = (pmem_read || pmem_write) && !pmem_resp;
            prev_write   = pmem_write;
            prev_addr    = pmem_address;
            prev_wdata   = pmem_wdata;
            prev_resp    = mem_resp;
        end else begin
            prev_pending = 1'b0;
            prev_resp    = 1'b0;
        end
    end

    initial begin
        l2_cache_pkg::line_t data;
        logic [31:0]         r;
        int                  writes_before;
        rst_n        = 1'b0;
        mem_address  = '0;
        mem_wdata256 = '0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        errors       = 0;
        cycle_count  = 0;
        seed         = 32'hd85f_1e99;
        pmem_reads   = 0;
        pmem_writes  = 0;
        prev_pending = 1'b0;
        prev_resp    = 1'b0;
        use_time     = 0;
        for (int s = 0; s < num_sets; s++) begin
            for (int w = 0; w < num_ways; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
                m_used[s][w]  = 0;
            end
        end
        for (int i = 0; i < 128; i++) begin
            shadow_ok[i] = 1'b0;
        end

        repeat (10) begin
            @(negedge clk);
            check_idle();
        end
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end

        // read miss, read hit, write hit, read back
        writes_before = pmem_writes;
        cache_access(1'b0, make_addr(2, 1), '0);
        cache_access(1'b0, make_addr(2, 1), '0);
        random_line(data);
        cache_access(1'b1, make_addr(2, 1), data);
        cache_access(1'b0, make_addr(2, 1), '0);
        assert (pmem_writes == writes_before)
            else report_error("pmem_write before the dirty line was evicted");

        // five tags in set 5, the first one dirty
        random_line(data);
        cache_access(1'b1, make_addr(0, 5), data);
        for (int t = 1; t < 4; t++) begin
            cache_access(1'b0, make_addr(t, 5), '0);
        end
        writes_before = pmem_writes;
        cache_access(1'b0, make_addr(4, 5), '0);
        assert (pmem_writes == writes_before + 1 && wb_addr === make_addr(0, 5))
            else report_error("fifth tag did not write back the dirty first line");
        writes_before = pmem_writes;
        cache_access(1'b0, make_addr(5, 5), '0);   // clean victim
        cache_access(1'b0, make_addr(0, 5), '0);   // written line comes back from pmem
        assert (pmem_writes == writes_before)
            else report_error("clean eviction caused a pmem write");

        for (int i = 0; i < random_ops; i++) begin
            r = $random(seed);
            random_line(data);
            cache_access(r[8], make_addr(r[7:2] % 6, r[1:0]), data);
        end

        $display("summary: %0d errors, %0d pmem reads, %0d pmem writes, %0d cycles",
                 errors, pmem_reads, pmem_writes, cycle_count);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule : l2_cache_tb

`default_nettype wire

// ==== files.f ====
src/l2_cache_pkg.sv
src/l2_way_if.sv
src/l2_cache_way.sv
src/l2_cache_control.sv
src/l2_way_select.sv
src/l2_cache.sv
tests/l2_pmem_model.sv
tests/l2_cache_tb.sv
